/* lsu_pkg.sv */
// Shared widths and funct3 codes; byte lanes assume a data width that is a multiple of 8.
package lsu_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Data and address width.
    localparam int unsigned XLEN = 32;

    // One enable per byte lane.
    localparam int unsigned BE_W = XLEN / 8;

    ////////////////////////////////////////
    // Access size and sign (funct3)
    ////////////////////////////////////////

    // Signed byte.
    localparam logic [2:0] F3_B  = 3'd0;

    // Signed halfword.
    localparam logic [2:0] F3_H  = 3'd1;

    // Full word.
    localparam logic [2:0] F3_W  = 3'd2;

    // Unsigned byte for loads only.
    localparam logic [2:0] F3_BU = 3'd4;

    // Unsigned halfword for loads only.
    localparam logic [2:0] F3_HU = 3'd5;

    // Stores use only F3_B, F3_H and F3_W.
    // Bit 2 of funct3 marks zero extension on loads.

endpackage

/* mem_access_unit.sv */
// One request in flight at a time; misaligned addresses are not trapped and unused low bits are ignored.
module mem_access_unit import lsu_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,

    // Request from execute.
    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  logic            req_store_i,
    input  logic [2:0]      req_funct3_i,
    input  logic [XLEN-1:0] req_addr_i,
    input  logic [XLEN-1:0] req_wdata_i,

    // Response to writeback.
    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output logic [XLEN-1:0] rsp_rdata_o,

    // Data memory bus.
    output logic            mem_sel_o,
    output logic            mem_we_o,
    output logic [BE_W-1:0] mem_be_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    input  logic [XLEN-1:0] mem_rdata_i,
    input  logic            mem_stall_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } state_t;

    state_t state_q;
    state_t state_d;

    // Held request.
    logic            store_q;
    logic [2:0]      funct3_q;
    logic [XLEN-3:0] word_q;
    logic [1:0]      off_q;
    logic [XLEN-1:0] wdata_q;

    // Response payload.
    logic [XLEN-1:0] rsp_rdata_q;

    logic            req_fire;
    logic            rsp_fire;
    logic            mem_done;

    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata_lane;
    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [XLEN-1:0] load_data;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    assign req_fire = req_valid_i && req_ready_o;
    assign rsp_fire = rsp_valid_o && rsp_ready_i;
    assign mem_done = mem_sel_o && !mem_stall_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_fire) begin
                    state_d = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                if (mem_done) begin
                    state_d = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (rsp_fire) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESPOND);

    // Fields are captured on acceptance and held until the next one.
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            store_q  <= req_store_i;
            funct3_q <= req_funct3_i;
            word_q   <= req_addr_i[XLEN-1:2];
            off_q    <= req_addr_i[1:0];
            wdata_q  <= req_wdata_i;
        end
    end

    ////////////////////////////////////////
    // Store formatting
    ////////////////////////////////////////

    always_comb begin
        case (funct3_q)
            F3_B, F3_BU: begin
                be         = 4'b0001 << off_q;
                wdata_lane = wdata_q << {off_q, 3'b000};
            end
            F3_H, F3_HU: begin
                be         = off_q[1] ? 4'b1100 : 4'b0011;
                wdata_lane = off_q[1] ? (wdata_q << 16) : wdata_q;
            end
            default: begin
                be         = 4'b1111;
                wdata_lane = wdata_q;
            end
        endcase
    end

    assign mem_sel_o   = (state_q == ST_ACCESS);
    assign mem_we_o    = mem_sel_o && store_q;
    assign mem_be_o    = be;
    assign mem_addr_o  = {word_q, 2'b00};
    assign mem_wdata_o = wdata_lane;

    ////////////////////////////////////////
    // Load extraction
    ////////////////////////////////////////

    assign byte_lane = mem_rdata_i[{off_q, 3'b000} +: 8];
    assign half_lane = mem_rdata_i[{off_q[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3_q)
            F3_B:    load_data = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            F3_BU:   load_data = {{(XLEN-8){1'b0}}, byte_lane};
            F3_H:    load_data = {{(XLEN-16){half_lane[15]}}, half_lane};
            F3_HU:   load_data = {{(XLEN-16){1'b0}}, half_lane};
            F3_W:    load_data = mem_rdata_i;
            default: load_data = mem_rdata_i;
        endcase
    end

    // Stores answer with zero.
    always_ff @(posedge clk_i) begin
        if (mem_done) begin
            rsp_rdata_q <= store_q ? '0 : load_data;
        end
    end

    assign rsp_rdata_o = rsp_rdata_q;

endmodule

/* data_mem.sv */
// Word RAM with no reset on its contents; MEM_WORDS must be a power of two and high address bits wrap.
module data_mem import lsu_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256,
    parameter int unsigned MEM_WAIT  = 2
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            sel_i,
    input  logic            we_i,
    input  logic [BE_W-1:0] be_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            stall_o
);

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int unsigned CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(MEM_WAIT);

    logic [XLEN-1:0]  mem_q [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] cnt_q;
    logic             done;

    // Word index sits above the byte offset.
    assign idx = addr_i[2 +: IDX_W];

    ////////////////////////////////////////
    // Wait states
    ////////////////////////////////////////

    assign stall_o = sel_i && (cnt_q != WAIT_LAST);
    assign done    = sel_i && !stall_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (done) begin
            cnt_q <= '0;
        end else if (stall_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Array
    ////////////////////////////////////////

    // Only enabled lanes change, on the completing edge.
    always_ff @(posedge clk_i) begin
        if (done && we_i) begin
            for (int i = 0; i < BE_W; i++) begin
                if (be_i[i]) begin
                    mem_q[idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // Read is combinational from the held address.
    assign rdata_o = mem_q[idx];

endmodule

/* mem_stage_top.sv */
// Memory stage with its own data RAM; MEM_WORDS must be a power of two and MEM_WAIT may be zero.
module mem_stage_top import lsu_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256,
    parameter int unsigned MEM_WAIT  = 2
) (
    input  logic            clk_i,
    input  logic            arst_n_i,

    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  logic            req_store_i,
    input  logic [2:0]      req_funct3_i,
    input  logic [XLEN-1:0] req_addr_i,
    input  logic [XLEN-1:0] req_wdata_i,

    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output logic [XLEN-1:0] rsp_rdata_o
);

    // Data memory bus.
    logic            mem_sel;
    logic            mem_we;
    logic [BE_W-1:0] mem_be;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;
    logic            mem_stall;

    mem_access_unit lsu_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_store_i  (req_store_i),
        .req_funct3_i (req_funct3_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_rdata_o  (rsp_rdata_o),
        .mem_sel_o    (mem_sel),
        .mem_we_o     (mem_we),
        .mem_be_o     (mem_be),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .mem_stall_i  (mem_stall)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_WAIT  (MEM_WAIT)
    ) dmem_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .sel_i    (mem_sel),
        .we_i     (mem_we),
        .be_i     (mem_be),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .rdata_o  (mem_rdata),
        .stall_o  (mem_stall)
    );

endmodule

/* tb_clk_gen.sv */
// Free-running clock from time zero; reset is released a quarter period after its last edge.
module tb_clk_gen #(
    parameter int unsigned PERIOD       = 40,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

    // Reset is held from time zero.
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(PERIOD / 4);
        arst_n_o = 1'b1;
    end

endmodule

/* tb_mem_stage.sv */
// Reads mem_patterns.txt from the project root; the byte model assumes MEM_WORDS 256 and MEM_WAIT 2.
module tb_mem_stage import lsu_pkg::*; ();

    localparam int unsigned MEM_WORDS   = 256;
    localparam int unsigned MEM_WAIT    = 2;
    localparam int unsigned MEM_BYTES   = MEM_WORDS * 4;
    localparam int unsigned TIMEOUT     = 100;
    localparam int unsigned DRIVE_DELAY = 5;

    logic            clk;
    logic            arst_n;
    logic            req_valid;
    logic            req_ready;
    logic            req_store;
    logic [2:0]      req_funct3;
    logic [XLEN-1:0] req_addr;
    logic [XLEN-1:0] req_wdata;
    logic            rsp_valid;
    logic            rsp_ready;
    logic [XLEN-1:0] rsp_rdata;

    // Reference model of memory with one entry per byte.
    logic [7:0]      model_mem   [MEM_BYTES];
    logic            model_known [MEM_BYTES];
    integer          seed;

    tb_clk_gen #(
        .PERIOD       (40),
        .RESET_CYCLES (16)
    ) clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_stage_top #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_WAIT  (MEM_WAIT)
    ) dut_i (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_store_i  (req_store),
        .req_funct3_i (req_funct3),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .rsp_valid_o  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .rsp_rdata_o  (rsp_rdata)
    );

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL time %0t %s expected %08h got %08h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("At time %0t: %s", $time, msg);
        abort_run();
    endtask

    // Inputs change a few units after the rising edge while outputs are stable.
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    function automatic logic pick_ready();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[0];
    endfunction

    ////////////////////////////////////////
    // Byte model
    ////////////////////////////////////////

    function automatic int unsigned byte_index(input logic [31:0] addr);
        return addr % MEM_BYTES;
    endfunction

    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [31:0] base;
        int unsigned n;
        base = addr;
        n = 0;
        case (f3)
            F3_B: n = 1;
            F3_H: begin
                base = {addr[31:1], 1'b0};
                n = 2;
            end
            F3_W: begin
                base = {addr[31:2], 2'b00};
                n = 4;
            end
            default: report_problem("Pattern file error: store with funct3 other than B, H or W");
        endcase
        // Little endian order puts byte k of the data at base + k.
        for (int k = 0; k < n; k++) begin
            model_mem[byte_index(base + k)]   = data[8*k +: 8];
            model_known[byte_index(base + k)] = 1'b1;
        end
    endtask

    task automatic model_load(input logic [2:0] f3, input logic [31:0] addr,
                              output logic [31:0] value);
        logic [31:0] base;
        logic [31:0] raw;
        int unsigned n;
        base = addr;
        raw = '0;
        n = 0;
        case (f3)
            F3_B, F3_BU: n = 1;
            F3_H, F3_HU: begin
                base = {addr[31:1], 1'b0};
                n = 2;
            end
            F3_W: begin
                base = {addr[31:2], 2'b00};
                n = 4;
            end
            default: report_problem("Pattern file error: load with an unknown funct3");
        endcase
        for (int k = 0; k < n; k++) begin
            if (!model_known[byte_index(base + k)]) begin
                report_problem("Pattern file error: load reads a byte no earlier store wrote");
            end
            raw[8*k +: 8] = model_mem[byte_index(base + k)];
        end
        case (f3)
            F3_B:    value = {{24{raw[7]}}, raw[7:0]};
            F3_H:    value = {{16{raw[15]}}, raw[15:0]};
            default: value = raw;
        endcase
    endtask

    ////////////////////////////////////////
    // One access, request to response
    ////////////////////////////////////////

    task automatic run_access(input logic store, input logic [2:0] f3, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] expected);
        int unsigned waited;
        int unsigned latency;
        int unsigned held;
        logic [31:0] first_data;
        req_valid  = 1'b1;
        req_store  = store;
        req_funct3 = f3;
        req_addr   = addr;
        req_wdata  = wdata;
        waited = 0;
        while (req_ready !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                report_problem("Timeout: req_ready_o stayed low for 100 cycles");
            end
            next_cycle();
            waited++;
        end
        // Transfer happens on this edge.
        next_cycle();
        req_valid = 1'b0;
        latency = 0;
        while (rsp_valid !== 1'b1) begin
            assert (req_ready === 1'b0)
                else report_mismatch("req_ready_o", 32'd0, {31'd0, req_ready});
            if (latency >= TIMEOUT) begin
                report_problem("Timeout: rsp_valid_o did not rise within 100 cycles");
            end
            rsp_ready = pick_ready();
            next_cycle();
            latency++;
        end
        assert (latency == MEM_WAIT + 1)
            else report_mismatch("rsp_valid_o latency", MEM_WAIT + 1, latency);
        assert (rsp_rdata === expected)
            else report_mismatch("rsp_rdata_o", expected, rsp_rdata);
        assert (req_ready === 1'b0)
            else report_mismatch("req_ready_o", 32'd0, {31'd0, req_ready});
        first_data = rsp_rdata;
        held = 0;
        rsp_ready = pick_ready();
        while (rsp_ready !== 1'b1) begin
            if (held >= TIMEOUT) begin
                report_problem("Timeout: response was held back for 100 cycles");
            end
            next_cycle();
            held++;
            assert (rsp_valid === 1'b1)
                else report_mismatch("rsp_valid_o", 32'd1, {31'd0, rsp_valid});
            assert (rsp_rdata === first_data)
                else report_mismatch("rsp_rdata_o", first_data, rsp_rdata);
            assert (req_ready === 1'b0)
                else report_mismatch("req_ready_o", 32'd0, {31'd0, req_ready});
            rsp_ready = pick_ready();
        end
        // Response handshake edge.
        next_cycle();
        rsp_ready = 1'b0;
        assert (rsp_valid === 1'b0)
            else report_mismatch("rsp_valid_o", 32'd0, {31'd0, rsp_valid});
        assert (req_ready === 1'b1)
            else report_mismatch("req_ready_o", 32'd1, {31'd0, req_ready});
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int          fd;
        int          count;
        string       line;
        logic [31:0] f_store;
        logic [31:0] f_f3;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        logic [31:0] model_value;
        int unsigned line_no;
        int unsigned n_access;
        int unsigned waited;
        seed       = 32'hd27f2603;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_funct3 = 3'd0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_ready  = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_known[i] = 1'b0;
        end
        waited = 0;
        while (arst_n !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                report_problem("Timeout: reset was not released");
            end
            next_cycle();
            waited++;
        end
        assert (req_ready === 1'b1)
            else report_mismatch("req_ready_o", 32'd1, {31'd0, req_ready});
        assert (rsp_valid === 1'b0)
            else report_mismatch("rsp_valid_o", 32'd0, {31'd0, rsp_valid});
        fd = $fopen("mem_patterns.txt", "r");
        if (fd == 0) begin
            report_problem("Cannot open mem_patterns.txt");
        end
        line_no = 0;
        n_access = 0;
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            line_no++;
            if (count > 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n"
                    && line[0] != "\r") begin
                count = $sscanf(line, "%h %h %h %h %h", f_store, f_f3, f_addr, f_wdata, f_exp);
                if (count != 5 || f_store > 1 || f_f3 > 7) begin
                    report_problem($sformatf("Pattern file error: line %0d is malformed", line_no));
                end
                if (f_store[0]) begin
                    model_store(f_f3[2:0], f_addr, f_wdata);
                    model_value = '0;
                end else begin
                    model_load(f_f3[2:0], f_addr, model_value);
                end
                if (model_value !== f_exp) begin
                    report_problem($sformatf(
                        "Pattern file error: line %0d expects %08h but earlier stores give %08h",
                        line_no, f_exp, model_value));
                end
                run_access(f_store[0], f_f3[2:0], f_addr, f_wdata, f_exp);
                n_access++;
            end
        end
        $fclose(fd);
        if (n_access == 0) begin
            report_problem("No accesses found in mem_patterns.txt");
        end else begin
            $display("%0d accesses run", n_access);
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* mem_patterns.txt */
# Columns in hex: store flag, funct3, address, write data, expected response.
# Stores expect 0; loads expect the extended result of all earlier stores.
1 2 00000000 deadbeef 00000000
0 2 00000000 00000000 deadbeef
1 2 00000004 12345678 00000000
0 2 00000004 00000000 12345678
1 2 00000008 80ff7f01 00000000
1 2 0000000c 00000000 00000000
1 2 00000010 cafef00d 00000000
0 0 00000008 00000000 00000001
0 0 00000009 00000000 0000007f
0 0 0000000a 00000000 ffffffff
0 0 0000000b 00000000 ffffff80
0 4 00000008 00000000 00000001
0 4 00000009 00000000 0000007f
0 4 0000000a 00000000 000000ff
0 4 0000000b 00000000 00000080
0 0 00000000 00000000 ffffffef
0 4 00000003 00000000 000000de
0 0 00000001 00000000 ffffffbe
0 4 00000002 00000000 000000ad
0 1 00000008 00000000 00007f01
0 1 0000000a 00000000 ffff80ff
0 5 00000008 00000000 00007f01
0 5 0000000a 00000000 000080ff
0 1 00000009 00000000 00007f01
0 5 0000000b 00000000 000080ff
0 1 0000000b 00000000 ffff80ff
0 1 00000000 00000000 ffffbeef
0 5 00000000 00000000 0000beef
0 1 00000002 00000000 ffffdead
0 5 00000003 00000000 0000dead
0 1 00000004 00000000 00005678
0 5 00000006 00000000 00001234
1 0 0000000c 000000aa 00000000
0 2 0000000c 00000000 000000aa
1 0 0000000d ffffffbb 00000000
0 2 0000000c 00000000 0000bbaa
1 0 0000000e 111111cc 00000000
0 2 0000000c 00000000 00ccbbaa
1 0 0000000f 000000dd 00000000
0 2 0000000c 00000000 ddccbbaa
0 0 0000000f 00000000 ffffffdd
0 4 0000000e 00000000 000000cc
1 1 00000010 abcd1234 00000000
0 2 00000010 00000000 cafe1234
1 1 00000012 00008765 00000000
0 2 00000010 00000000 87651234
1 1 00000011 0000beef 00000000
0 2 00000010 00000000 8765beef
0 1 00000012 00000000 ffff8765
0 5 00000010 00000000 0000beef
1 2 00000017 01020304 00000000
0 2 00000014 00000000 01020304
0 4 00000017 00000000 00000001
1 2 00000418 a5a5a5a5 00000000
0 2 00000018 00000000 a5a5a5a5
1 0 0000001a 0000003c 00000000
0 2 00000418 00000000 a53ca5a5
1 2 000003fc 7e7e7e7e 00000000
0 2 000003fc 00000000 7e7e7e7e
0 0 000003ff 00000000 0000007e

/* tb.f */
lsu_pkg.sv
mem_access_unit.sv
data_mem.sv
mem_stage_top.sv
tb_clk_gen.sv
tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - lsu_pkg.sv
  - mem_access_unit.sv
  - data_mem.sv
  - mem_stage_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem_stage.sv
